// ==== hw/pcie_macros.svh ====
`ifndef PCIE_MACROS_SVH
`define PCIE_MACROS_SVH

// ============================================================
// Stream and BAR geometry
// ============================================================

// Width of one stream beat, one dword.
`define PCIE_DATA_WIDTH 32

// BAR 0 size in byte address bits.
`define BAR0_APERTURE 8

// Dword address bits inside BAR 0.
`define BAR0_ADDR_WIDTH (`BAR0_APERTURE - 2)

// Number of dwords in the BAR 0 register memory.
`define BAR0_WORDS (1 << `BAR0_ADDR_WIDTH)

// ============================================================
// Request buffering
// ============================================================

// Default entry count of the request FIFO.
`define REQ_FIFO_DEPTH 4

`endif

// ==== hw/tlp_pkg.sv ====
package tlp_pkg;

    // ============================================================
    // TLP header encodings
    // ============================================================

    // Format and type byte, bits 31:24 of header dword 0.
    typedef enum logic [7:0] {
        // 3DW header, no data.
        mem_rd32 = 8'h00,
        // 3DW header, with data.
        mem_wr32 = 8'h40,
        // Completion with data.
        cpl_d    = 8'h4A
    } fmt_type_e;

    // ============================================================
    // Header field widths
    // ============================================================

    // Requester id, bits 31:16 of header dword 1.
    localparam int REQ_ID_WIDTH = 16;

    // Tag, bits 15:8 of header dword 1.
    localparam int TAG_WIDTH = 8;

    // Length in dwords, bits 9:0 of header dword 0.
    localparam int LEN_WIDTH = 10;

endpackage

// ==== hw/core_pkg.sv ====
package core_pkg;

    // Request kinds passed from decoder to engine.
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } req_op_e;

    // Receive decoder states, one per expected beat.
    typedef enum logic [2:0] {
        s_hdr0,
        s_hdr1,
        s_addr,
        s_data,
        s_drop,
        s_push
    } rx_state_e;

    // Completion engine states.
    typedef enum logic [2:0] {
        s_idle,
        s_rd,
        s_cpl0,
        s_cpl1,
        s_cpl2
    } cpl_state_e;

endpackage

// ==== hw/tlp_rx_decode.sv ====
`include "pcie_macros.svh"

module tlp_rx_decode (
    input  logic                             clk,
    input  logic                             reset,

    input  logic [`PCIE_DATA_WIDTH-1:0]      rx_st_data,
    input  logic                             rx_st_sop,
    input  logic                             rx_st_eop,
    input  logic                             rx_st_valid,
    input  logic [2:0]                       rx_st_bar_range,
    output logic                             rx_st_ready,

    output core_pkg::req_op_e                req_op,
    output logic [`BAR0_ADDR_WIDTH-1:0]      req_addr,
    output logic [`PCIE_DATA_WIDTH-1:0]      req_data,
    output logic [tlp_pkg::REQ_ID_WIDTH-1:0] req_req_id,
    output logic [tlp_pkg::TAG_WIDTH-1:0]    req_tag,
    output logic                             req_valid,
    input  logic                             req_ready
);

    core_pkg::rx_state_e state;

    // Beat handshake on the receive stream.
    logic beat;

    // Header dword 0 fields, taken straight off the bus.
    tlp_pkg::fmt_type_e hdr_fmt;
    logic               hdr_ok;

    assign beat = rx_st_valid && rx_st_ready;

    // Stall the stream while a finished request waits.
    assign rx_st_ready = (state != core_pkg::s_push);
    assign req_valid   = (state == core_pkg::s_push);

    assign hdr_fmt = tlp_pkg::fmt_type_e'(rx_st_data[31:24]);

    // Only single-dword memory accesses to BAR 0.
    assign hdr_ok = (hdr_fmt == tlp_pkg::mem_rd32 || hdr_fmt == tlp_pkg::mem_wr32)
        && (rx_st_data[tlp_pkg::LEN_WIDTH-1:0] == 1)
        && (rx_st_bar_range == 3'd0);

    // ============================================================
    // Packet state machine
    // ============================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::s_hdr0;
        end else begin
            case (state)
                core_pkg::s_hdr0: begin
                    if (beat) begin
                        // A one-beat packet is always short.
                        if (rx_st_sop && hdr_ok && !rx_st_eop) begin
                            state <= core_pkg::s_hdr1;
                        end else if (!rx_st_eop) begin
                            state <= core_pkg::s_drop;
                        end
                    end
                end
                core_pkg::s_hdr1: begin
                    // Early eop ends the packet here, nothing kept.
                    if (beat) begin
                        state <= rx_st_eop ? core_pkg::s_hdr0 : core_pkg::s_addr;
                    end
                end
                core_pkg::s_addr: begin
                    if (beat) begin
                        if (req_op == core_pkg::op_write) begin
                            // Writes need one more beat.
                            state <= rx_st_eop ? core_pkg::s_hdr0 : core_pkg::s_data;
                        end else begin
                            // Reads end here, or they are too long.
                            state <= rx_st_eop ? core_pkg::s_push : core_pkg::s_drop;
                        end
                    end
                end
                core_pkg::s_data: begin
                    if (beat) begin
                        state <= rx_st_eop ? core_pkg::s_push : core_pkg::s_drop;
                    end
                end
                core_pkg::s_drop: begin
                    // Swallow the rest of a rejected packet.
                    if (beat && rx_st_eop) begin
                        state <= core_pkg::s_hdr0;
                    end
                end
                core_pkg::s_push: begin
                    if (req_ready) begin
                        state <= core_pkg::s_hdr0;
                    end
                end
                default: begin
                    state <= core_pkg::s_hdr0;
                end
            endcase
        end
    end

    // ============================================================
    // Field capture
    // ============================================================

    always_ff @(posedge clk) begin
        if (beat) begin
            case (state)
                core_pkg::s_hdr0: begin
                    req_op <= (hdr_fmt == tlp_pkg::mem_wr32) ?
                        core_pkg::op_write : core_pkg::op_read;
                end
                core_pkg::s_hdr1: begin
                    req_req_id <= rx_st_data[31 -: tlp_pkg::REQ_ID_WIDTH];
                    req_tag    <= rx_st_data[15 -: tlp_pkg::TAG_WIDTH];
                end
                core_pkg::s_addr: begin
                    // Dword address, wrapped to the aperture.
                    req_addr <= rx_st_data[`BAR0_APERTURE-1:2];
                end
                core_pkg::s_data: begin
                    req_data <= rx_st_data;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== hw/req_fifo.sv ====
`include "pcie_macros.svh"

module req_fifo #(
    parameter int DEPTH = `REQ_FIFO_DEPTH
) (
    input  logic                             clk,
    input  logic                             reset,

    input  core_pkg::req_op_e                in_op,
    input  logic [`BAR0_ADDR_WIDTH-1:0]      in_addr,
    input  logic [`PCIE_DATA_WIDTH-1:0]      in_data,
    input  logic [tlp_pkg::REQ_ID_WIDTH-1:0] in_req_id,
    input  logic [tlp_pkg::TAG_WIDTH-1:0]    in_tag,
    input  logic                             in_valid,
    output logic                             in_ready,

    output core_pkg::req_op_e                out_op,
    output logic [`BAR0_ADDR_WIDTH-1:0]      out_addr,
    output logic [`PCIE_DATA_WIDTH-1:0]      out_data,
    output logic [tlp_pkg::REQ_ID_WIDTH-1:0] out_req_id,
    output logic [tlp_pkg::TAG_WIDTH-1:0]    out_tag,
    output logic                             out_valid,
    input  logic                             out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage, one array per field.
    core_pkg::req_op_e                op_mem     [DEPTH];
    logic [`BAR0_ADDR_WIDTH-1:0]      addr_mem   [DEPTH];
    logic [`PCIE_DATA_WIDTH-1:0]      data_mem   [DEPTH];
    logic [tlp_pkg::REQ_ID_WIDTH-1:0] req_id_mem [DEPTH];
    logic [tlp_pkg::TAG_WIDTH-1:0]    tag_mem    [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    assign out_valid = (count != 0);
    // A full FIFO still takes a push when the head leaves.
    assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Head entry shown directly.
    assign out_op     = op_mem[rd_ptr];
    assign out_addr   = addr_mem[rd_ptr];
    assign out_data   = data_mem[rd_ptr];
    assign out_req_id = req_id_mem[rd_ptr];
    assign out_tag    = tag_mem[rd_ptr];

    // Pointers and occupancy.
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone.
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry write.
    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]     <= in_op;
            addr_mem[wr_ptr]   <= in_addr;
            data_mem[wr_ptr]   <= in_data;
            req_id_mem[wr_ptr] <= in_req_id;
            tag_mem[wr_ptr]    <= in_tag;
        end
    end

endmodule

// ==== hw/bar_cpl_engine.sv ====
`include "pcie_macros.svh"

module bar_cpl_engine (
    input  logic                             clk,
    input  logic                             reset,

    input  core_pkg::req_op_e                req_op,
    input  logic [`BAR0_ADDR_WIDTH-1:0]      req_addr,
    input  logic [`PCIE_DATA_WIDTH-1:0]      req_data,
    input  logic [tlp_pkg::REQ_ID_WIDTH-1:0] req_req_id,
    input  logic [tlp_pkg::TAG_WIDTH-1:0]    req_tag,
    input  logic                             req_valid,
    output logic                             req_ready,

    output logic [`PCIE_DATA_WIDTH-1:0]      tx_st_data,
    output logic                             tx_st_sop,
    output logic                             tx_st_eop,
    output logic                             tx_st_valid,
    input  logic                             tx_st_ready
);

    // Completion dword 0 padding between type and length.
    localparam int HDR0_PAD = `PCIE_DATA_WIDTH - 8 - tlp_pkg::LEN_WIDTH;
    // Completion dword 1 padding below the tag.
    localparam int HDR1_PAD =
        `PCIE_DATA_WIDTH - tlp_pkg::REQ_ID_WIDTH - tlp_pkg::TAG_WIDTH;
    localparam logic [tlp_pkg::LEN_WIDTH-1:0] CPL_LEN = 1;

    core_pkg::cpl_state_e state;

    // BAR 0 register memory.
    logic [`PCIE_DATA_WIDTH-1:0] mem [`BAR0_WORDS];

    // Saved read request.
    logic [`BAR0_ADDR_WIDTH-1:0]      rd_addr;
    logic [tlp_pkg::REQ_ID_WIDTH-1:0] rd_req_id;
    logic [tlp_pkg::TAG_WIDTH-1:0]    rd_tag;
    logic [`PCIE_DATA_WIDTH-1:0]      rd_data;

    logic req_take;

    // Requests only enter while idle.
    assign req_ready = (state == core_pkg::s_idle);
    assign req_take  = req_valid && req_ready;

    // ============================================================
    // Control and memory write
    // ============================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::s_idle;
            // Registers read back as zero after reset.
            for (int i = 0; i < `BAR0_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                core_pkg::s_idle: begin
                    if (req_take) begin
                        if (req_op == core_pkg::op_write) begin
                            // Posted write, no completion.
                            mem[req_addr] <= req_data;
                        end else begin
                            state <= core_pkg::s_rd;
                        end
                    end
                end
                core_pkg::s_rd: begin
                    state <= core_pkg::s_cpl0;
                end
                core_pkg::s_cpl0: begin
                    if (tx_st_ready) begin
                        state <= core_pkg::s_cpl1;
                    end
                end
                core_pkg::s_cpl1: begin
                    if (tx_st_ready) begin
                        state <= core_pkg::s_cpl2;
                    end
                end
                core_pkg::s_cpl2: begin
                    if (tx_st_ready) begin
                        state <= core_pkg::s_idle;
                    end
                end
                default: begin
                    state <= core_pkg::s_idle;
                end
            endcase
        end
    end

    // ============================================================
    // Read path
    // ============================================================

    always_ff @(posedge clk) begin
        if (req_take) begin
            rd_addr   <= req_addr;
            rd_req_id <= req_req_id;
            rd_tag    <= req_tag;
        end
        // One-cycle memory fetch.
        if (state == core_pkg::s_rd) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Completion beats built from state.
    always_comb begin
        tx_st_valid = 1'b0;
        tx_st_sop   = 1'b0;
        tx_st_eop   = 1'b0;
        tx_st_data  = '0;
        case (state)
            core_pkg::s_cpl0: begin
                tx_st_valid = 1'b1;
                tx_st_sop   = 1'b1;
                tx_st_data  = {tlp_pkg::cpl_d, {HDR0_PAD{1'b0}}, CPL_LEN};
            end
            core_pkg::s_cpl1: begin
                tx_st_valid = 1'b1;
                tx_st_data  = {rd_req_id, rd_tag, {HDR1_PAD{1'b0}}};
            end
            core_pkg::s_cpl2: begin
                tx_st_valid = 1'b1;
                tx_st_eop   = 1'b1;
                tx_st_data  = rd_data;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/fpga_core.sv ====
`include "pcie_macros.svh"

module fpga_core (
    input  logic                        clk,
    input  logic                        reset,

    input  logic [`PCIE_DATA_WIDTH-1:0] rx_st_data,
    input  logic                        rx_st_sop,
    input  logic                        rx_st_eop,
    input  logic                        rx_st_valid,
    input  logic [2:0]                  rx_st_bar_range,
    output logic                        rx_st_ready,

    output logic [`PCIE_DATA_WIDTH-1:0] tx_st_data,
    output logic                        tx_st_sop,
    output logic                        tx_st_eop,
    output logic                        tx_st_valid,
    input  logic                        tx_st_ready
);

    // Decoder to FIFO.
    core_pkg::req_op_e                dec_op;
    logic [`BAR0_ADDR_WIDTH-1:0]      dec_addr;
    logic [`PCIE_DATA_WIDTH-1:0]      dec_data;
    logic [tlp_pkg::REQ_ID_WIDTH-1:0] dec_req_id;
    logic [tlp_pkg::TAG_WIDTH-1:0]    dec_tag;
    logic                             dec_valid;
    logic                             dec_ready;

    // FIFO to engine.
    core_pkg::req_op_e                eng_op;
    logic [`BAR0_ADDR_WIDTH-1:0]      eng_addr;
    logic [`PCIE_DATA_WIDTH-1:0]      eng_data;
    logic [tlp_pkg::REQ_ID_WIDTH-1:0] eng_req_id;
    logic [tlp_pkg::TAG_WIDTH-1:0]    eng_tag;
    logic                             eng_valid;
    logic                             eng_ready;

    tlp_rx_decode tlp_rx_decode_inst (
        .clk(clk),
        .reset(reset),
        .rx_st_data(rx_st_data),
        .rx_st_sop(rx_st_sop),
        .rx_st_eop(rx_st_eop),
        .rx_st_valid(rx_st_valid),
        .rx_st_bar_range(rx_st_bar_range),
        .rx_st_ready(rx_st_ready),
        .req_op(dec_op),
        .req_addr(dec_addr),
        .req_data(dec_data),
        .req_req_id(dec_req_id),
        .req_tag(dec_tag),
        .req_valid(dec_valid),
        .req_ready(dec_ready)
    );

    req_fifo #(
        .DEPTH(`REQ_FIFO_DEPTH)
    ) req_fifo_inst (
        .clk(clk),
        .reset(reset),
        .in_op(dec_op),
        .in_addr(dec_addr),
        .in_data(dec_data),
        .in_req_id(dec_req_id),
        .in_tag(dec_tag),
        .in_valid(dec_valid),
        .in_ready(dec_ready),
        .out_op(eng_op),
        .out_addr(eng_addr),
        .out_data(eng_data),
        .out_req_id(eng_req_id),
        .out_tag(eng_tag),
        .out_valid(eng_valid),
        .out_ready(eng_ready)
    );

    bar_cpl_engine bar_cpl_engine_inst (
        .clk(clk),
        .reset(reset),
        .req_op(eng_op),
        .req_addr(eng_addr),
        .req_data(eng_data),
        .req_req_id(eng_req_id),
        .req_tag(eng_tag),
        .req_valid(eng_valid),
        .req_ready(eng_ready),
        .tx_st_data(tx_st_data),
        .tx_st_sop(tx_st_sop),
        .tx_st_eop(tx_st_eop),
        .tx_st_valid(tx_st_valid),
        .tx_st_ready(tx_st_ready)
    );

endmodule

// ==== tests/fpga_core_checker.sv ====
`include "pcie_macros.svh"

module fpga_core_checker (
    input logic                        clk,
    input logic                        reset,
    input logic [`PCIE_DATA_WIDTH-1:0] tx_st_data,
    input logic                        tx_st_sop,
    input logic                        tx_st_eop,
    input logic                        tx_st_valid,
    input logic                        tx_st_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Stalled beat must hold until taken.
    tx_hold: assert property (@(posedge clk) disable iff (reset)
        tx_st_valid && !tx_st_ready |=> tx_st_valid && $stable(tx_st_data))
        else $error("transmit beat changed while stalled");

    // Packet markers only on a live beat.
    tx_marks: assert property (@(posedge clk) disable iff (reset)
        (tx_st_sop || tx_st_eop) |-> tx_st_valid)
        else $error("sop or eop seen without valid");

    // Engine comes out of reset idle.
    tx_reset: assert property (@(posedge clk) reset |=> !tx_st_valid)
        else $error("transmit valid high right after reset");

endmodule

// ==== tests/tb_fpga_core.sv ====
`include "pcie_macros.svh"

module tb_fpga_core;
    timeunit 1ns;
    timeprecision 1ps;

    // ============================================================
    // Test sizes and run limit
    // ============================================================

    localparam int N_RW   = 16;
    localparam int N_WRAP = 8;
    localparam int N_RAND = 40;
    localparam int WORDS  = 64;
    // Upper bound on beats sent over all tests.
    localparam int TOTAL_BEATS = WORDS * 3 + N_RW * 7 + N_WRAP * 7 + 26 + 15 + N_RAND * 4;
    localparam int CYCLE_LIMIT = 10 * TOTAL_BEATS + 200;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] rx_st_data;
    logic        rx_st_sop;
    logic        rx_st_eop;
    logic        rx_st_valid;
    logic [2:0]  rx_st_bar_range;
    logic        rx_st_ready;
    logic [31:0] tx_st_data;
    logic        tx_st_sop;
    logic        tx_st_eop;
    logic        tx_st_valid;
    logic        tx_st_ready;

    // Model memory and expected beats as {sop, eop, data}.
    logic [31:0] model_mem [WORDS];
    logic [33:0] exp_q [$];
    logic [33:0] exp_beat;

    logic [31:0] lfsr;
    logic        stress;
    int          cycles;
    int          errors;
    int          test_errors;
    int          beats_checked;

    fpga_core UUT (
        .clk(clk),
        .reset(reset),
        .rx_st_data(rx_st_data),
        .rx_st_sop(rx_st_sop),
        .rx_st_eop(rx_st_eop),
        .rx_st_valid(rx_st_valid),
        .rx_st_bar_range(rx_st_bar_range),
        .rx_st_ready(rx_st_ready),
        .tx_st_data(tx_st_data),
        .tx_st_sop(tx_st_sop),
        .tx_st_eop(tx_st_eop),
        .tx_st_valid(tx_st_valid),
        .tx_st_ready(tx_st_ready)
    );

    bind fpga_core fpga_core_checker checker_inst (
        .clk(clk),
        .reset(reset),
        .tx_st_data(tx_st_data),
        .tx_st_sop(tx_st_sop),
        .tx_st_eop(tx_st_eop),
        .tx_st_valid(tx_st_valid),
        .tx_st_ready(tx_st_ready)
    );

    always #4 clk = ~clk;

    // ============================================================
    // Random source
    // ============================================================

    // Galois step with taps x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // ============================================================
    // Stimulus
    // ============================================================

    // Advance one cycle and change inputs 1 ns after the edge.
    task automatic tick();
        @(posedge clk);
        #1;
        tx_st_ready = stress ? rand_bits(1) : 1'b1;
    endtask

    task automatic send_beat(input logic [31:0] data, input logic sop, input logic eop,
                             input logic [2:0] bar);
        logic taken;
        // Random idle cycles between beats.
        if (stress) begin
            while (rand_bits(2) == 0) begin
                tick();
            end
        end
        rx_st_data      = data;
        rx_st_sop       = sop;
        rx_st_eop       = eop;
        rx_st_bar_range = bar;
        rx_st_valid     = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            // Ready only moves on an edge.
            taken = rx_st_ready;
            tick();
        end
        rx_st_valid = 1'b0;
        rx_st_sop   = 1'b0;
        rx_st_eop   = 1'b0;
    endtask

    // Header, id, address and data beats with eop on the last.
    task automatic send_packet(input logic [7:0] fmt, input logic [9:0] len,
                               input logic [2:0] bar, input logic [29:0] addr,
                               input logic [31:0] data, input logic [15:0] req_id,
                               input logic [7:0] tag, input int n_beats);
        logic [31:0] beat;
        for (int i = 0; i < n_beats; i++) begin
            case (i)
                0: beat = {fmt, 14'h0, len};
                1: beat = {req_id, tag, 8'h00};
                2: beat = {addr, 2'b00};
                default: beat = data;
            endcase
            send_beat(beat, i == 0, i == n_beats - 1, bar);
        end
    endtask

    task automatic send_write(input logic [29:0] addr, input logic [31:0] data);
        send_packet(8'h40, 10'd1, 3'd0, addr, data, rand_bits(16), rand_bits(8), 4);
        // Aperture is 64 dwords.
        model_mem[addr[5:0]] = data;
    endtask

    task automatic send_read(input logic [29:0] addr);
        logic [15:0] req_id;
        logic [7:0]  tag;
        req_id = rand_bits(16);
        tag    = rand_bits(8);
        send_packet(8'h00, 10'd1, 3'd0, addr, 32'h0, req_id, tag, 3);
        // Completion with data of length 1.
        exp_q.push_back({2'b10, 8'h4A, 14'h0, 10'd1});
        exp_q.push_back({2'b00, req_id, tag, 8'h00});
        exp_q.push_back({2'b01, model_mem[addr[5:0]]});
    endtask

    // Wait out all completions and then watch for strays.
    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            tick();
        end
        repeat (20) begin
            tick();
        end
        $display("Test %s finished with %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    // ============================================================
    // Transmit monitor
    // ============================================================

    // Sampled mid-cycle away from the edge.
    always @(negedge clk) begin
        if (!reset && tx_st_valid && tx_st_ready) begin
            beats_checked++;
            if (exp_q.size() == 0) begin
                $display("Unexpected completion beat at %0d ns, data %h", $time, tx_st_data);
                test_errors++;
            end else begin
                exp_beat = exp_q.pop_front();
                if ({tx_st_sop, tx_st_eop, tx_st_data} != exp_beat) begin
                    $display("Error at %0d ns: beat sop %b eop %b data %h, expected %b %b %h",
                             $time, tx_st_sop, tx_st_eop, tx_st_data,
                             exp_beat[33], exp_beat[32], exp_beat[31:0]);
                    test_errors++;
                end
            end
        end
    end

    // Run limit.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d completion beats never arrived",
                     cycles, exp_q.size());
            $display("Something failed");
            $finish;
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        logic [5:0]  rw_addr [N_RW];
        logic [5:0]  a;
        logic [23:0] hi;
        reset           = 1'b1;
        rx_st_data      = '0;
        rx_st_sop       = 1'b0;
        rx_st_eop       = 1'b0;
        rx_st_valid     = 1'b0;
        rx_st_bar_range = 3'd0;
        tx_st_ready     = 1'b1;
        lfsr            = 32'hc24c;
        stress          = 1'b0;
        cycles          = 0;
        errors          = 0;
        test_errors     = 0;
        beats_checked   = 0;
        for (int i = 0; i < WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;

        // Cleared memory before any write.
        for (int i = 0; i < WORDS; i++) begin
            send_read(30'(i));
        end
        finish_test("reset state");

        for (int i = 0; i < N_RW; i++) begin
            rw_addr[i] = rand_bits(6);
            send_write(30'(rw_addr[i]), rand_bits(32));
        end
        for (int i = 0; i < N_RW; i++) begin
            send_read(30'(rw_addr[i]));
        end
        finish_test("write then read");

        // Upper address bits beyond the aperture are ignored.
        for (int i = 0; i < N_WRAP; i++) begin
            a  = rand_bits(6);
            hi = rand_bits(24) | 24'h1;
            send_write({hi, a}, rand_bits(32));
            send_read(30'(a));
        end
        finish_test("aperture wrap");

        // Bad fmt, bad length, bad BAR, short and long writes.
        a = rand_bits(6);
        send_packet(8'h20, 10'd1, 3'd0, 30'(a), 32'hdead_0001, 16'h1, 8'h1, 4);
        send_packet(8'h40, 10'd2, 3'd0, 30'(a + 6'd1), 32'hdead_0002, 16'h2, 8'h2, 4);
        send_packet(8'h40, 10'd1, 3'd1, 30'(a + 6'd2), 32'hdead_0003, 16'h3, 8'h3, 4);
        send_packet(8'h40, 10'd1, 3'd0, 30'(a + 6'd3), 32'hdead_0004, 16'h4, 8'h4, 3);
        send_packet(8'h40, 10'd1, 3'd0, 30'(a + 6'd4), 32'hdead_0005, 16'h5, 8'h5, 5);
        // Long and short reads.
        send_packet(8'h00, 10'd1, 3'd0, 30'(a), 32'h0, 16'h6, 8'h6, 4);
        send_packet(8'h00, 10'd1, 3'd0, 30'(a), 32'h0, 16'h7, 8'h7, 2);
        for (int i = 0; i < 5; i++) begin
            send_read(30'(a + 6'(i)));
        end
        finish_test("unsupported packets");

        // Random mix under stalls and gaps.
        stress = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            a = rand_bits(6);
            if (rand_bits(1)) begin
                send_write(30'(a), rand_bits(32));
            end else begin
                send_read(30'(a));
            end
        end
        finish_test("back-pressure");
        stress = 1'b0;

        $display("Beats checked %0d, errors %0d", beats_checked, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== fpga_core.f ====
+incdir+hw
hw/tlp_pkg.sv
hw/core_pkg.sv
hw/tlp_rx_decode.sv
hw/req_fifo.sv
hw/bar_cpl_engine.sv
hw/fpga_core.sv
tests/fpga_core_checker.sv
tests/tb_fpga_core.sv

// ==== Bender.yml ====
package:
  name: fpga_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/tlp_pkg.sv
      - hw/core_pkg.sv
      - hw/tlp_rx_decode.sv
      - hw/req_fifo.sv
      - hw/bar_cpl_engine.sv
      - hw/fpga_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/fpga_core_checker.sv
      - tests/tb_fpga_core.sv
